// ==== src/backend_cfg.svh ====
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// datapath sizes
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// primary opcodes, inst[31:26]
`define OPC_SPECIAL 6'h00
`define OPC_ADDIU   6'h09
`define OPC_ORI     6'h0D

// SPECIAL funct codes, inst[5:0]
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_SLT      6'h2A

`endif

// ==== src/backend_pkg.sv ====
`include "backend_cfg.svh"

package backend_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // decoded instruction, decode -> execute
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        alu_op_e                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        logic                   wen;
    } uop_t;

    // execute -> result
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } result_t;

    // retirement record
    typedef struct packed {
        logic                   valid;
        logic                   exc;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module decode_unit import backend_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             inst_valid_i,
    input  logic [`XLEN-1:0] inst_i,
    input  logic             flush_i,
    output uop_t             uop_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    uop_t       uop_d;
    uop_t       uop_q;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];

    always_comb begin
        uop_d         = '0;
        uop_d.valid   = inst_valid_i && !flush_i;
        uop_d.op      = ALU_ADD;
        uop_d.rs      = inst_i[25:21];
        uop_d.rt      = inst_i[20:16];
        case (opcode)
            `OPC_SPECIAL: begin
                uop_d.rd = inst_i[15:11];
                case (funct)
                    `FN_ADDU: uop_d.op = ALU_ADD;
                    `FN_SUBU: uop_d.op = ALU_SUB;
                    `FN_AND:  uop_d.op = ALU_AND;
                    `FN_OR:   uop_d.op = ALU_OR;
                    `FN_XOR:  uop_d.op = ALU_XOR;
                    `FN_SLT:  uop_d.op = ALU_SLT;
                    default:  uop_d.illegal = 1'b1;
                endcase
            end
            `OPC_ADDIU: begin
                uop_d.rd      = inst_i[20:16];
                uop_d.use_imm = 1'b1;
                uop_d.imm     = {{(`XLEN-16){inst_i[15]}}, inst_i[15:0]};
            end
            `OPC_ORI: begin
                uop_d.op      = ALU_OR;
                uop_d.rd      = inst_i[20:16];
                uop_d.use_imm = 1'b1;
                uop_d.imm     = {{(`XLEN-16){1'b0}}, inst_i[15:0]};
            end
            default: uop_d.illegal = 1'b1;
        endcase
        // unknown encodings become 0 + 0 into r0 so the retired data is zero
        if (uop_d.illegal) begin
            uop_d.op      = ALU_ADD;
            uop_d.rs      = '0;
            uop_d.rt      = '0;
            uop_d.rd      = '0;
            uop_d.use_imm = 1'b1;
            uop_d.imm     = '0;
        end
        uop_d.wen = !uop_d.illegal && (uop_d.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            uop_q.valid <= 1'b0;
        end else begin
            uop_q <= uop_d;
        end
    end

    assign uop_o = uop_q;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`REG_ADDR_W-1:0] raddr_b_i,
    output logic [`XLEN-1:0]       rdata_a_o,
    output logic [`XLEN-1:0]       rdata_b_o,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // r0 is hardwired and its storage entry is never read
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // decode drops wen for rd == 0, so r0 is never written
    a_no_r0_write: assert property (@(posedge clk)
        we_i |-> waddr_i != '0);

endmodule

// ==== src/alu_execute.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module alu_execute import backend_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  uop_t                   uop_i,
    output logic [`REG_ADDR_W-1:0] rs_addr_o,
    output logic [`REG_ADDR_W-1:0] rt_addr_o,
    input  logic [`XLEN-1:0]       rs_data_i,
    input  logic [`XLEN-1:0]       rt_data_i,
    input  logic                   fwd_we_i,
    input  logic [`REG_ADDR_W-1:0] fwd_addr_i,
    input  logic [`XLEN-1:0]       fwd_data_i,
    output result_t                result_o
);

    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    result_t          res_q;

    assign rs_addr_o = uop_i.rs;
    assign rt_addr_o = uop_i.rt;

    // bypass from the result stage whose rf write lands at the end of this cycle
    assign src_a = (fwd_we_i && fwd_addr_i == uop_i.rs) ? fwd_data_i : rs_data_i;
    assign src_b = (fwd_we_i && fwd_addr_i == uop_i.rt) ? fwd_data_i : rt_data_i;
    assign op_b  = uop_i.use_imm ? uop_i.imm : src_b;

    always_comb begin
        case (uop_i.op)
            ALU_ADD: alu_res = src_a + op_b;
            ALU_SUB: alu_res = src_a - op_b;
            ALU_AND: alu_res = src_a & op_b;
            ALU_OR:  alu_res = src_a | op_b;
            ALU_XOR: alu_res = src_a ^ op_b;
            ALU_SLT: begin
                alu_res = ($signed(src_a) < $signed(op_b)) ? `XLEN'd1 : `XLEN'd0;
            end
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q.valid   <= uop_i.valid && !flush_i;
            res_q.illegal <= uop_i.illegal;
            res_q.wen     <= uop_i.wen;
            res_q.rd      <= uop_i.rd;
            res_q.data    <= alu_res;
        end
    end

    assign result_o = res_q;

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module result_stage import backend_pkg::*; (
    input  result_t                result_i,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]       rf_wdata_o,
    output wb_t                    wb_o
);

    // same write feeds the rf and the execute bypass
    assign rf_we_o    = result_i.valid && result_i.wen && !result_i.illegal;
    assign rf_waddr_o = result_i.rd;
    assign rf_wdata_o = result_i.data;

    always_comb begin
        wb_o.valid = result_i.valid;
        wb_o.exc   = result_i.valid && result_i.illegal;
        wb_o.wen   = rf_we_o;
        wb_o.rd    = result_i.rd;
        wb_o.data  = result_i.data;
    end

    // an exception arrives with its write already dropped upstream
    always_comb begin
        if (wb_o.exc) begin
            a_exc_no_write: assert (!result_i.wen);
        end
    end

endmodule

// ==== src/backend_top.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_top import backend_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             inst_valid_i,
    input  logic [`XLEN-1:0] inst_i,
    input  logic             flush_i,
    output wb_t              wb_o
);

    uop_t                   uop;
    result_t                result;
    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic [`XLEN-1:0]       rs_data;
    logic [`XLEN-1:0]       rt_data;
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;

    decode_unit u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .flush_i      (flush_i),
        .uop_o        (uop)
    );

    alu_execute u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .uop_i      (uop),
        .rs_addr_o  (rs_addr),
        .rt_addr_o  (rt_addr),
        .rs_data_i  (rs_data),
        .rt_data_i  (rt_data),
        .fwd_we_i   (rf_we),
        .fwd_addr_i (rf_waddr),
        .fwd_data_i (rf_wdata),
        .result_o   (result)
    );

    reg_file u_rf (
        .clk       (clk),
        .raddr_a_i (rs_addr),
        .raddr_b_i (rt_addr),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    result_stage u_result (
        .result_i   (result),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .wb_o       (wb_o)
    );

endmodule

// ==== bench/backend_tb.sv ====
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_tb import backend_pkg::*; ();

    localparam int N_LOAD    = 16;
    localparam int N_RAND    = 200;
    localparam int N_CHAINS  = 3;
    localparam int CHAIN_LEN = 12;
    localparam int N_MISC    = 9;
    localparam int N_ROUNDS  = 10;
    localparam int ROUND_LEN = 6;
    localparam int N_IDLE    = 18;
    localparam int N_CYCLES  = N_LOAD + N_RAND + N_CHAINS * CHAIN_LEN + N_MISC
                             + N_ROUNDS * ROUND_LEN + N_IDLE;
    localparam int WATCHDOG_NS = N_CYCLES * 8 + 200;

    typedef struct packed {
        int unsigned      due;
        int unsigned      sample;
        logic             exc;
        logic             wen;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic [`XLEN-1:0] prev;
    } exp_t;

    logic             clk = 1'b0;
    logic             rst_n_i;
    logic             inst_valid_i;
    logic [`XLEN-1:0] inst_i;
    logic             flush_i;
    wb_t              wb_o;

    logic [`XLEN-1:0] model [`NUM_REGS];
    exp_t             exp_q [$];
    exp_t             exp_rec = '0;
    logic             exp_valid = 1'b0;
    int unsigned      edge_cnt = 0;

    backend_top uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .flush_i      (flush_i),
        .wb_o         (wb_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // head of the queue becomes the expectation for the coming edge
    always @(negedge clk) begin
        exp_valid = 1'b0;
        exp_rec   = '0;
        if (exp_q.size() > 0) begin
            if (exp_q[0].due == edge_cnt) begin
                exp_valid = 1'b1;
                exp_rec   = exp_q.pop_front();
            end
        end
    end

    a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.valid == exp_valid)
        else value_error($sformatf("wb_o.valid=%0b, expected %0b",
            $sampled(wb_o.valid), exp_valid));

    a_wb_record: assert property (@(posedge clk) disable iff (!rst_n_i)
        exp_valid |-> wb_o.exc == exp_rec.exc && wb_o.wen == exp_rec.wen
            && (exp_rec.exc || (wb_o.rd == exp_rec.rd && wb_o.data == exp_rec.data)))
        else value_error($sformatf("wb_o exc=%0b wen=%0b rd=%0d data=%h, expected %0b %0b %0d %h",
            $sampled(wb_o.exc), $sampled(wb_o.wen), $sampled(wb_o.rd), $sampled(wb_o.data),
            exp_rec.exc, exp_rec.wen, exp_rec.rd, exp_rec.data));

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run aborted");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {`OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(8, 1));
    endfunction

    function automatic logic [31:0] rand_inst(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd);
        logic [31:0] inst;
        logic [15:0] imm;
        imm = 16'($urandom);
        case ($urandom_range(7, 0))
            0: inst = enc_r(`FN_ADDU, rs, rt, rd);
            1: inst = enc_r(`FN_SUBU, rs, rt, rd);
            2: inst = enc_r(`FN_AND, rs, rt, rd);
            3: inst = enc_r(`FN_OR, rs, rt, rd);
            4: inst = enc_r(`FN_XOR, rs, rt, rd);
            5: inst = enc_r(`FN_SLT, rs, rt, rd);
            6: inst = enc_i(`OPC_ADDIU, rs, rd, imm);
            default: inst = enc_i(`OPC_ORI, rs, rd, imm);
        endcase
        return inst;
    endfunction

    // reference decode and ALU applied in program order
    task automatic predict(input logic [31:0] inst, input int unsigned smp, output exp_t e);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        rs  = inst[25:21];
        rt  = inst[20:16];
        a   = model[rs];
        b   = model[rt];
        rd  = 5'd0;
        res = '0;
        ok  = 1'b1;
        if (inst[31:26] == `OPC_SPECIAL) begin
            rd = inst[15:11];
            case (inst[5:0])
                `FN_ADDU: res = a + b;
                `FN_SUBU: res = a - b;
                `FN_AND:  res = a & b;
                `FN_OR:   res = a | b;
                `FN_XOR:  res = a ^ b;
                `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:  ok = 1'b0;
            endcase
        end else if (inst[31:26] == `OPC_ADDIU) begin
            rd  = rt;
            res = a + {{16{inst[15]}}, inst[15:0]};
        end else if (inst[31:26] == `OPC_ORI) begin
            rd  = rt;
            res = a | {16'h0000, inst[15:0]};
        end else begin
            ok = 1'b0;
        end
        if (!ok) begin
            rd = 5'd0;
        end
        e.sample = smp;
        e.due    = smp + 1;
        e.exc    = !ok;
        e.wen    = ok && (rd != 5'd0);
        e.rd     = rd;
        e.data   = res;
        e.prev   = model[rd];
        if (e.wen) begin
            model[rd] = res;
        end
    endtask

    // the instruction in the result stage has already retired by the flush edge
    task automatic squash(input int unsigned smp);
        exp_t e;
        while (exp_q.size() > 0 && exp_q[$].sample + 1 >= smp) begin
            e = exp_q.pop_back();
            if (e.wen) begin
                model[e.rd] = e.prev;
            end
        end
    endtask

    task automatic drive(input logic valid, input logic [31:0] inst, input logic flush);
        int unsigned smp;
        exp_t        e;
        @(posedge clk);
        #1;
        inst_valid_i = valid;
        inst_i       = inst;
        flush_i      = flush;
        smp          = edge_cnt + 1;
        if (flush) begin
            squash(smp);
        end else if (valid) begin
            predict(inst, smp, e);
            exp_q.push_back(e);
        end
    endtask

    task automatic run_chains();
        logic [4:0] rd;
        logic [4:0] nrd;
        for (int c = 0; c < N_CHAINS; c++) begin
            rd = pick_reg();
            drive(1'b1, rand_inst(pick_reg(), pick_reg(), rd), 1'b0);
            for (int i = 1; i < CHAIN_LEN; i++) begin
                nrd = pick_reg();
                drive(1'b1, rand_inst(rd, (i % 2 == 0) ? rd : pick_reg(), nrd), 1'b0);
                rd = nrd;
            end
        end
    endtask

    task automatic run_flush_rounds();
        logic [4:0] victim;
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int i = 0; i < ROUND_LEN - 2; i++) begin
                victim = pick_reg();
                drive(1'b1, rand_inst(pick_reg(), pick_reg(), victim), 1'b0);
            end
            drive(1'b1, rand_inst(pick_reg(), pick_reg(), pick_reg()), 1'b1);
            // read back what the squashed instruction would have written
            drive(1'b1, enc_r(`FN_ADDU, victim, pick_reg(), pick_reg()), 1'b0);
        end
    endtask

    initial begin
        void'($urandom(39));
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        flush_i      = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // quiet pipeline after reset
        repeat (5) drive(1'b0, '0, 1'b0);

        for (int r = 1; r <= N_LOAD / 2; r++) begin
            drive(1'b1, enc_i(`OPC_ORI, 5'd0, 5'(r), 16'($urandom)), 1'b0);
            drive(1'b1, enc_i(`OPC_ADDIU, 5'(r), 5'(r), 16'($urandom)), 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            drive(1'b1, rand_inst(pick_reg(), pick_reg(), pick_reg()), 1'b0);
        end
        run_chains();

        // writes to r0 are dropped and r0 reads back as zero
        drive(1'b1, enc_r(`FN_ADDU, 5'd1, 5'd2, 5'd0), 1'b0);
        drive(1'b1, enc_i(`OPC_ORI, 5'd5, 5'd0, 16'h1234), 1'b0);
        drive(1'b1, enc_r(`FN_OR, 5'd0, 5'd0, 5'd3), 1'b0);
        drive(1'b1, enc_r(`FN_ADDU, 5'd0, 5'd4, 5'd6), 1'b0);

        // unknown encodings
        drive(1'b1, enc_i(6'h3F, 5'd1, 5'd2, 16'hBEEF), 1'b0);
        drive(1'b1, {`OPC_SPECIAL, 5'd3, 5'd4, 5'd5, 5'd0, 6'h00}, 1'b0);
        drive(1'b1, enc_i(6'h23, 5'd6, 5'd7, 16'h0040), 1'b0);
        drive(1'b1, enc_r(`FN_OR, 5'd2, 5'd7, 5'd3), 1'b0);
        drive(1'b1, enc_r(`FN_XOR, 5'd5, 5'd7, 5'd8), 1'b0);

        run_flush_rounds();

        drive(1'b0, '0, 1'b0);
        repeat (4) @(posedge clk);
        #1;
        if (exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected records never retired", exp_q.size()));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog timeout, the run did not finish in time");
    end

endmodule

// ==== all.f ====
+incdir+src
src/backend_pkg.sv
src/decode_unit.sv
src/reg_file.sv
src/alu_execute.sv
src/result_stage.sv
src/backend_top.sv
bench/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module backend_tb -o backend_tb_sim

# a $fatal in the bench gives a nonzero exit status
./obj_dir/backend_tb_sim
